// ==== apb_client.sv ====
`timescale 1ns/1ps

module apb_client
(
    input                        clk,
    input                        rst,
    input                        trig,
    output logic                 req,
    input                        gnt,
    input  arb_pkg::client_idx_t id,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output apb_pkg::apb_addr_t   paddr,
    output apb_pkg::apb_data_t   pwdata,
    input  apb_pkg::apb_data_t   prdata,
    input                        pready
);

    import apb_pkg::*;

    logic       trig_s1;
    logic       trig_s2;
    logic       trig_d;
    logic       rise;
    logic       pending;
    apb_phase_t phase;
    apb_data_t  rdata_q;

    //------------------------------------------------------------------------
    // key sync, edge detect, pending request

    assign rise = trig_s2 & ~ trig_d;

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            trig_s1 <= 1'b0;
            trig_s2 <= 1'b0;
            trig_d  <= 1'b0;
            pending <= 1'b0;
        end
        else
        begin
            trig_s1 <= trig;
            trig_s2 <= trig_s1;
            trig_d  <= trig_s2;

            // clear wins over a new edge, edges while pending are absorbed
            if (phase == ph_release)
                pending <= 1'b0;
            else if (rise)
                pending <= 1'b1;
        end
    end

    // dropped in release so the arbiter can let go
    assign req = pending & (phase != ph_release);

    //------------------------------------------------------------------------
    // read-modify-write master

    always_ff @ (posedge clk)
    begin
        if (rst)
            phase <= ph_wait;
        else
        begin
            case (phase)
                ph_wait:      if (gnt && pending) phase <= ph_rd_setup;
                ph_rd_setup:  phase <= ph_rd_access;
                ph_rd_access: if (pready) phase <= ph_wr_setup;
                ph_wr_setup:  phase <= ph_wr_access;
                ph_wr_access: if (pready) phase <= ph_release;
                default:      phase <= ph_wait;
            endcase
        end
    end

    // read data, kept for the write
    always_ff @ (posedge clk)
    begin
        if (phase == ph_rd_access && pready)
            rdata_q <= prdata;
    end

    assign psel    = (phase != ph_wait) & (phase != ph_release);
    assign penable = (phase == ph_rd_access) | (phase == ph_wr_access);
    assign pwrite  = (phase == ph_wr_setup)  | (phase == ph_wr_access);

    // own counter lives at own index
    assign paddr   = id;
    assign pwdata  = rdata_q + 1'b1;

endmodule

// ==== apb_pkg.sv ====
package apb_pkg;

    //------------------------------------------------------------------------
    // apb bus between the clients and the counter bank

    // bank address, one word per client
    typedef logic [2:0] apb_addr_t;

    // counter word
    typedef logic [7:0] apb_data_t;

    // client master sequence, one read-modify-write per grant
    typedef enum logic [2:0]
    {
        ph_wait,
        ph_rd_setup,
        ph_rd_access,
        ph_wr_setup,
        ph_wr_access,
        ph_release
    }
    apb_phase_t;

endpackage

// ==== apb_share.sv ====
`timescale 1ns/1ps

module apb_share
(
    input                                              clk,
    input                                              rst,
    input                                              ena,
    input  arb_pkg::client_vec_t                       req,
    output arb_pkg::client_vec_t                       gnt,

    // per-client master side
    input  arb_pkg::client_vec_t                       m_psel,
    input  arb_pkg::client_vec_t                       m_penable,
    input  arb_pkg::client_vec_t                       m_pwrite,
    input  apb_pkg::apb_addr_t [arb_pkg::n_clients - 1:0] m_paddr,
    input  apb_pkg::apb_data_t [arb_pkg::n_clients - 1:0] m_pwdata,

    // shared bus toward the bank
    output logic                                       psel,
    output logic                                       penable,
    output logic                                       pwrite,
    output apb_pkg::apb_addr_t                         paddr,
    output apb_pkg::apb_data_t                         pwdata
);

    import arb_pkg::*;

    //------------------------------------------------------------------------
    // round-robin arbiter, plain level req and gnt

    rr_arbiter i_arbiter
    (
        .clk ( clk ),
        .rst ( rst ),
        .ena ( ena ),
        .req ( req ),
        .gnt ( gnt )
    );

    //------------------------------------------------------------------------
    // and-or mux on the one-hot grant
    // no grant gives an all-zero idle bus

    always_comb
    begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        for (int i = 0; i < n_clients; i++)
        begin
            if (gnt [i])
            begin
                psel    = psel    | m_psel    [i];
                penable = penable | m_penable [i];
                pwrite  = pwrite  | m_pwrite  [i];
                paddr   = paddr   | m_paddr   [i];
                pwdata  = pwdata  | m_pwdata  [i];
            end
        end
    end

endmodule

// ==== arb_pkg.sv ====
package arb_pkg;

    //------------------------------------------------------------------------
    // peer clients sharing the bank

    // four keys plus four switches
    localparam int n_clients = 8;

    // one bit per client, used for req and gnt
    typedef logic [n_clients - 1:0] client_vec_t;

    // client number, also the bank address
    typedef logic [$clog2 (n_clients) - 1:0] client_idx_t;

    //------------------------------------------------------------------------
    // arbiter fsm

    typedef enum logic
    {
        arb_idle,
        // grant held until owner drops req
        arb_owned
    }
    arb_state_t;

endpackage

// ==== grant_counters.sv ====
`timescale 1ns/1ps

module grant_counters
(
    input                                              clk,
    input                                              rst,

    // apb slave side
    input                                              psel,
    input                                              penable,
    input                                              pwrite,
    input  apb_pkg::apb_addr_t                         paddr,
    input  apb_pkg::apb_data_t                         pwdata,
    output apb_pkg::apb_data_t                         prdata,
    output logic                                       pready,

    // all counters for the display
    output apb_pkg::apb_data_t [arb_pkg::n_clients - 1:0] cnt_all
);

    import arb_pkg::*;
    import apb_pkg::*;

    apb_data_t [n_clients - 1:0] cnt;
    logic                        wr_en;

    //------------------------------------------------------------------------
    // zero wait states

    assign pready = 1'b1;

    // write lands in the access cycle
    assign wr_en = psel & penable & pwrite & pready;

    always_ff @ (posedge clk)
    begin
        if (rst)
            cnt <= '0;
        else if (wr_en)
            cnt [paddr] <= pwdata;
    end

    //------------------------------------------------------------------------
    // read path, valid in setup and access

    assign prdata  = (psel && ! pwrite) ? cnt [paddr] : '0;

    assign cnt_all = cnt;

endmodule

// ==== lab_top.f ====
arb_pkg.sv
apb_pkg.sv
strobe_gen.sv
rr_arbiter.sv
apb_client.sv
apb_share.sv
grant_counters.sv
seg_display.sv
lab_top.sv
lab_top_props.sv
tb_clk_gen.sv
lab_top_tb.sv

// ==== lab_top.sv ====
`timescale 1ns/1ps

module lab_top
# (
    parameter clk_mhz   = 50,
              strobe_hz = 3,
              scan_div  = 1024
)
(
    input                        clk,
    input                        rst,

    // keys and switches are the request sources
    input        [3:0]           key,
    input        [3:0]           sw,
    output arb_pkg::client_vec_t led,

    output logic [7:0]           abcdefgh,
    output arb_pkg::client_vec_t digit,

    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output logic [15:0]          sound,
    output logic                 uart_tx
);

    import arb_pkg::*;
    import apb_pkg::*;

    //------------------------------------------------------------------------
    // unused board outputs

    assign red     = '0;
    assign green   = '0;
    assign blue    = '0;
    assign sound   = '0;
    assign uart_tx = 1'b1;

    //------------------------------------------------------------------------

    client_vec_t               trig;
    client_vec_t               req;
    client_vec_t               gnt;
    client_vec_t               m_psel;
    client_vec_t               m_penable;
    client_vec_t               m_pwrite;
    apb_addr_t [n_clients-1:0] m_paddr;
    apb_data_t [n_clients-1:0] m_pwdata;
    apb_data_t [n_clients-1:0] cnt_all;

    logic      enable;
    logic      psel;
    logic      penable;
    logic      pwrite;
    logic      pready;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;

    // key 0 is client 0, switches follow the keys
    assign trig = { sw, key };

    // one-hot owner on the leds
    assign led  = gnt;

    // slow grant pacing
    strobe_gen # (.clk_mhz (clk_mhz), .strobe_hz (strobe_hz)) i_strobe_gen
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .strobe ( enable )
    );

    //------------------------------------------------------------------------
    // peer clients, identical except for their index

    for (genvar i = 0; i < n_clients; i++)
    begin : g_client
        apb_client i_client
        (
            .clk     ( clk                 ),
            .rst     ( rst                 ),
            .trig    ( trig      [i]       ),
            .req     ( req       [i]       ),
            .gnt     ( gnt       [i]       ),
            .id      ( client_idx_t' (i)   ),
            .psel    ( m_psel    [i]       ),
            .penable ( m_penable [i]       ),
            .pwrite  ( m_pwrite  [i]       ),
            .paddr   ( m_paddr   [i]       ),
            .pwdata  ( m_pwdata  [i]       ),
            .prdata  ( prdata              ),
            .pready  ( pready              )
        );
    end

    //------------------------------------------------------------------------
    // arbitration and shared bus

    apb_share i_share
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .ena       ( enable    ),
        .req       ( req       ),
        .gnt       ( gnt       ),
        .m_psel    ( m_psel    ),
        .m_penable ( m_penable ),
        .m_pwrite  ( m_pwrite  ),
        .m_paddr   ( m_paddr   ),
        .m_pwdata  ( m_pwdata  ),
        .psel      ( psel      ),
        .penable   ( penable   ),
        .pwrite    ( pwrite    ),
        .paddr     ( paddr     ),
        .pwdata    ( pwdata    )
    );

    grant_counters i_counters
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .paddr   ( paddr   ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .cnt_all ( cnt_all )
    );

    seg_display # (.scan_div (scan_div)) i_display
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cnt_all  ( cnt_all  ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// ==== lab_top_props.sv ====
`timescale 1ns/1ps

module lab_top_props
(
    input                                                  clk,
    input                                                  rst,
    input  arb_pkg::client_vec_t                           req,
    input  arb_pkg::client_vec_t                           gnt,
    input                                                  psel,
    input                                                  penable,
    input                                                  pwrite,
    input  apb_pkg::apb_addr_t                             paddr,
    input  apb_pkg::apb_data_t                             pwdata,
    input  apb_pkg::apb_data_t                             prdata,
    input  apb_pkg::apb_data_t [arb_pkg::n_clients - 1:0] cnt_all
);

    import arb_pkg::*;
    import apb_pkg::*;

    int                           fail_cnt = 0;
    client_vec_t                  gnt_q;
    client_vec_t                  new_gnt;
    client_vec_t [n_clients-1:0] seen;
    client_vec_t                  twice;

    //------------------------------------------------------------------------
    // fairness tracking
    // seen [j] holds the clients granted since client j started waiting

    assign new_gnt = gnt & ~ gnt_q;

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            gnt_q <= '0;
            seen  <= '0;
        end
        else
        begin
            gnt_q <= gnt;
            for (int j = 0; j < n_clients; j++)
            begin
                if (! req [j] || gnt [j])
                    seen [j] <= '0;
                else
                    seen [j] <= seen [j] | new_gnt;
            end
        end
    end

    // a second grant to the same client while j still waits
    always_comb
    begin
        for (int j = 0; j < n_clients; j++)
            twice [j] = req [j] & ~ gnt [j] & (| (new_gnt & seen [j]));
    end

    //------------------------------------------------------------------------
    // grant

    a_reset_idle: assert property (@ (posedge clk)
        rst |=> (gnt == '0) && ! psel && ! penable)
        else begin $error ("bus not idle after reset"); fail_cnt++; end

    a_onehot: assert property (@ (posedge clk) disable iff (rst) $onehot0 (gnt))
        else begin $error ("grant is not one-hot"); fail_cnt++; end

    a_no_twice: assert property (@ (posedge clk) disable iff (rst) twice == '0)
        else begin $error ("client granted twice while another waits"); fail_cnt++; end

    // counters move only under their own grant
    for (genvar i = 0; i < n_clients; i++)
    begin : g_cnt
        a_cnt_owner: assert property (@ (posedge clk) disable iff (rst)
            $changed (cnt_all [i]) |-> $past (gnt [i]))
            else begin $error ("counter changed without its grant"); fail_cnt++; end
    end

    //------------------------------------------------------------------------
    // apb protocol

    a_access: assert property (@ (posedge clk) disable iff (rst)
        penable |-> psel && $past (psel) && ! $past (penable))
        else begin $error ("access cycle without setup"); fail_cnt++; end

    a_stable: assert property (@ (posedge clk) disable iff (rst)
        psel && ! penable |=> penable && $stable (paddr) && $stable (pwrite)
                              && $stable (pwdata))
        else begin $error ("address or control moved in access"); fail_cnt++; end

    a_addr_owner: assert property (@ (posedge clk) disable iff (rst) psel |-> gnt [paddr])
        else begin $error ("address is not the granted client"); fail_cnt++; end

    a_rmw: assert property (@ (posedge clk) disable iff (rst)
        psel && penable && ! pwrite |=> psel && ! penable && pwrite
                                        && (pwdata == $past (prdata) + 8'd1))
        else begin $error ("read not followed by write of data plus one"); fail_cnt++; end

endmodule

bind lab_top lab_top_props u_props
(
    .clk     ( clk     ),
    .rst     ( rst     ),
    .req     ( req     ),
    .gnt     ( gnt     ),
    .psel    ( psel    ),
    .penable ( penable ),
    .pwrite  ( pwrite  ),
    .paddr   ( paddr   ),
    .pwdata  ( pwdata  ),
    .prdata  ( prdata  ),
    .cnt_all ( cnt_all )
);

// ==== lab_top_tb.sv ====
`timescale 1ns/1ps

module lab_top_tb;

    import arb_pkg::*;

    localparam max_rounds     = 64;
    // presses times clients times 12 cycles per grant, plus scans and gaps
    localparam timeout_cycles = (2 + max_rounds) * n_clients * 12 + 2000;
    localparam grant_wait_max = n_clients * 12 + 16;

    // segments a..g then dp, a is the msb
    localparam logic [7:0] seg_tab [16] = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6,
        8'hbe, 8'he0, 8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};

    logic        clk;
    logic        rst;
    logic [3:0]  key;
    logic [3:0]  sw;
    client_vec_t led;
    logic [7:0]  abcdefgh;
    client_vec_t digit;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic [15:0] sound;
    logic        uart_tx;

    logic [7:0]  ref_cnt [n_clients];
    int          grant_order [$];
    int          grant_total = 0;
    client_vec_t led_q = '0;
    int          cycle = 0;
    int          errors = 0;
    int          test_start;
    int          tests = 0;
    int          tests_failed = 0;
    int          last_owner;
    int          first_owner;
    int          target_total;
    int          pick;
    int          rounds;
    bit          wrapped;
    client_vec_t pattern;

    tb_clk_gen # (.period_ns (4.0)) u_clk (.clk (clk));

    lab_top # (.clk_mhz (1), .strobe_hz (250000), .scan_div (4)) u_dut
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .key      ( key      ),
        .sw       ( sw       ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .sound    ( sound    ),
        .uart_tx  ( uart_tx  )
    );

    //------------------------------------------------------------------------
    // grant monitor, led rising edges in order

    always @ (negedge clk)
    begin
        for (int i = 0; i < n_clients; i++)
        begin
            if (led [i] && ! led_q [i])
            begin
                grant_order.push_back (i);
                grant_total++;
            end
        end
        led_q = led;
    end

    // run limit
    always @ (posedge clk)
    begin
        cycle++;
        if (cycle >= timeout_cycles)
        begin
            $display ("timeout after %0d cycles, grants never completed", cycle);
            $display ("Simulation finished: FAIL");
            $finish;
        end
    end

    //------------------------------------------------------------------------

    function automatic int error_total ();
        return errors + u_dut.u_props.fail_cnt;
    endfunction

    task automatic check_eq (input string name, input logic [15:0] exp,
                             input logic [15:0] act);
        assert (act == exp)
        else
        begin
            $display ("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic drive_trig (input client_vec_t value);
        @ (posedge clk);
        key <= value [3:0];
        sw  <= value [7:4];
    endtask

    // wait until target grants are seen and the bus is free again
    task automatic wait_grants (input int target);
        int n;
        n = 0;
        while ((grant_total < target || led_q != '0) && n < grant_wait_max)
        begin
            @ (posedge clk);
            n++;
        end
        assert (grant_total == target && led_q == '0)
        else
        begin
            $display ("grants did not complete, %0d of %0d seen", grant_total, target);
            errors++;
        end
    endtask

    // first grant seen and this client's led low again
    task automatic wait_first_release (input int client);
        int n;
        n = 0;
        while ((grant_order.size () == 0 || led_q [client]) && n < grant_wait_max)
        begin
            @ (posedge clk);
            n++;
        end
        assert (grant_order.size () > 0 && ! led_q [client])
        else
        begin
            $display ("client %0d was never granted and released", client);
            errors++;
        end
    endtask

    // three cycle trigger pulse, each edge adds one to its reference count
    task automatic pulse_trig (input client_vec_t value);
        drive_trig (value);
        repeat (2) @ (posedge clk);
        drive_trig ('0);
        for (int i = 0; i < n_clients; i++)
        begin
            if (value [i])
                ref_cnt [i] = ref_cnt [i] + 8'd1;
        end
    endtask

    task automatic press (input client_vec_t value);
        int target;
        target = grant_total + $countones (value);
        pulse_trig (value);
        wait_grants (target);
    endtask

    task automatic check_digit (input int i);
        int         n;
        logic [7:0] exp_seg;
        n = 0;
        exp_seg = seg_tab [ref_cnt [i][3:0]];
        @ (negedge clk);
        while (digit != (client_vec_t' (1) << i) && n < 2 * n_clients * 4)
        begin
            @ (negedge clk);
            n++;
        end
        assert (digit == (client_vec_t' (1) << i))
        else
        begin
            $display ("digit %0d was never selected by the scan", i);
            errors++;
        end
        assert (abcdefgh == exp_seg)
        else
        begin
            $display ("Fail abcdefgh on digit %0d: expected %h, actual %h",
                      i, exp_seg, abcdefgh);
            errors++;
        end
    endtask

    task automatic check_all_digits ();
        for (int i = 0; i < n_clients; i++)
            check_digit (i);
    endtask

    task automatic start_test ();
        test_start = error_total ();
        grant_order.delete ();
    endtask

    task automatic finish_test (input string name);
        tests++;
        if (error_total () == test_start)
            $display ("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display ("test %s: failed with %0d errors", name, error_total () - test_start);
        end
    endtask

    //------------------------------------------------------------------------

    initial
    begin
        void' ($urandom (32'h41402c10));
        rst = 1'b1;
        key = '0;
        sw  = '0;
        for (int i = 0; i < n_clients; i++)
            ref_cnt [i] = '0;
        // after reset the search starts at client 0
        last_owner = n_clients - 1;

        repeat (8) @ (posedge clk);
        rst <= 1'b0;

        // reset values
        start_test ();
        @ (negedge clk);
        assert (led == '0)
        else
        begin
            $display ("Fail led: expected %h, actual %h", 8'h00, led);
            errors++;
        end
        // unused board outputs tied off
        check_eq ("red",     16'h0000, red);
        check_eq ("green",   16'h0000, green);
        check_eq ("blue",    16'h0000, blue);
        check_eq ("sound",   16'h0000, sound);
        check_eq ("uart_tx", 16'h0001, uart_tx);
        check_all_digits ();
        finish_test ("reset_values");

        // one press, one grant on that client
        start_test ();
        pick = int' ($urandom % n_clients);
        press (client_vec_t' (1) << pick);
        assert (grant_order.size () == 1)
        else
        begin
            $display ("expected one grant for client %0d, saw %0d grants",
                      pick, grant_order.size ());
            errors++;
        end
        if (grant_order.size () > 0)
        begin
            assert (grant_order [0] == pick)
            else
            begin
                $display ("Fail led grant: expected client %h, actual %h",
                          pick, grant_order [0]);
                errors++;
            end
        end
        last_owner = pick;
        check_digit (pick);
        finish_test ("single_press");

        // all clients at once, cyclic after the last owner
        // first owner asks again while the rest still wait, so it comes last
        start_test ();
        first_owner  = (last_owner + 1) % n_clients;
        target_total = grant_total + n_clients + 1;
        pulse_trig ('1);
        wait_first_release (first_owner);
        pulse_trig (client_vec_t' (1) << first_owner);
        wait_grants (target_total);
        for (int k = 0; k <= n_clients; k++)
        begin
            assert (k < grant_order.size ()
                    && grant_order [k] == (last_owner + 1 + k) % n_clients)
            else
            begin
                $display ("Fail led grant %0d: expected client %h, actual %h",
                          k, (last_owner + 1 + k) % n_clients,
                          k < grant_order.size () ? grant_order [k] : -1);
                errors++;
            end
        end
        check_all_digits ();
        finish_test ("rotation");

        // random patterns until a digit wraps
        start_test ();
        rounds  = 0;
        wrapped = 1'b0;
        while (! wrapped && rounds < max_rounds)
        begin
            pattern = client_vec_t' ($urandom);
            if (pattern == '0)
                pattern = client_vec_t' (1) << ($urandom % n_clients);
            press (pattern);
            // idle gap so no edge meets a pending request
            repeat (n_clients) @ (posedge clk);
            for (int i = 0; i < n_clients; i++)
            begin
                if (ref_cnt [i] > 8'd16)
                    wrapped = 1'b1;
            end
            rounds++;
        end
        assert (wrapped)
        else
        begin
            $display ("random presses ended before any counter passed 16");
            errors++;
        end
        check_all_digits ();
        finish_test ("random_wrap");

        $display ("tests %0d, failed %0d, check errors %0d, property failures %0d",
                  tests, tests_failed, errors, u_dut.u_props.fail_cnt);
        if (error_total () == 0 && tests_failed == 0)
            $display ("Simulation finished: PASS");
        else
            $display ("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter
(
    input                        clk,
    input                        rst,
    input                        ena,
    input  arb_pkg::client_vec_t req,
    output arb_pkg::client_vec_t gnt
);

    import arb_pkg::*;

    arb_state_t  state;
    client_idx_t owner;

    client_idx_t                  start;
    logic [2 * n_clients - 1:0]   req_dbl;
    client_vec_t                  req_rot;
    client_vec_t                  gnt_rot;
    logic [2 * n_clients - 1:0]   gnt_dbl;
    client_vec_t                  nxt_gnt;
    client_idx_t                  offset;
    client_idx_t                  nxt_owner;

    //------------------------------------------------------------------------
    // rotate so the client after the last owner sits at bit 0

    assign start   = owner + client_idx_t' (1);
    assign req_dbl = { req, req } >> start;
    assign req_rot = req_dbl [n_clients - 1:0];

    // lowest set bit wins
    assign gnt_rot = req_rot & ~ (req_rot - 1'b1);

    // rotate the one-hot back into client order
    assign gnt_dbl = { gnt_rot, gnt_rot } << start;
    assign nxt_gnt = gnt_dbl [2 * n_clients - 1:n_clients];

    // position of the winner, counted from start
    always_comb
    begin
        offset = '0;
        for (int i = 0; i < n_clients; i++)
        begin
            if (gnt_rot [i])
                offset = client_idx_t' (i);
        end
    end

    assign nxt_owner = start + offset;

    //------------------------------------------------------------------------
    // fsm, new grants only on the strobe

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            state <= arb_idle;
            // so the first search starts at client 0
            owner <= client_idx_t' (n_clients - 1);
            gnt   <= '0;
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (ena && (| req))
                    begin
                        state <= arb_owned;
                        owner <= nxt_owner;
                        gnt   <= nxt_gnt;
                    end
                end
                arb_owned:
                begin
                    // owner done, free the bus next cycle
                    if (! req [owner])
                    begin
                        state <= arb_idle;
                        gnt   <= '0;
                    end
                end
                default:
                begin
                    state <= arb_idle;
                    gnt   <= '0;
                end
            endcase
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the lab_top testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module lab_top_tb \
    -f lab_top.f \
    -o lab_top_sim

# keep going on a failing run, the log decides
./obj_dir/lab_top_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log
then
    exit 0
else
    exit 1
fi

// ==== seg_display.sv ====
`timescale 1ns/1ps

module seg_display
# (
    parameter scan_div = 1024
)
(
    input                                              clk,
    input                                              rst,
    input  apb_pkg::apb_data_t [arb_pkg::n_clients - 1:0] cnt_all,
    output logic               [7:0]                   abcdefgh,
    output arb_pkg::client_vec_t                       digit
);

    import arb_pkg::*;
    import apb_pkg::*;

    localparam w_scan = scan_div > 1 ? $clog2 (scan_div) : 1;

    logic [w_scan - 1:0] scan_cnt;
    client_idx_t         idx;
    apb_data_t           cur;

    //------------------------------------------------------------------------
    // digit scan, one step every scan_div cycles

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            idx      <= '0;
        end
        else if (scan_cnt == w_scan' (scan_div - 1))
        begin
            scan_cnt <= '0;
            idx      <= idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // active high, digit i shows client i
    assign digit = client_vec_t' (1) << idx;
    assign cur   = cnt_all [idx];

    //------------------------------------------------------------------------
    // hex decode, a is the msb, dp off

    always_comb
    begin
        case (cur [3:0])
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;
        endcase
    end

endmodule

// ==== strobe_gen.sv ====
`timescale 1ns/1ps

module strobe_gen
# (
    parameter clk_mhz   = 50,
              strobe_hz = 3
)
(
    input        clk,
    input        rst,
    output logic strobe
);

    // clock cycles between strobes
    localparam period = clk_mhz * 1000 * 1000 / strobe_hz;
    localparam w_cnt  = period > 1 ? $clog2 (period) : 1;

    logic [w_cnt - 1:0] cnt;

    // free running down-counter, strobe on reload
    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            cnt    <= w_cnt' (period - 1);
            strobe <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt    <= w_cnt' (period - 1);
            strobe <= 1'b1;
        end
        else
        begin
            cnt    <= cnt - 1'b1;
            strobe <= 1'b0;
        end
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
# (
    parameter real period_ns = 4.0
)
(
    output logic clk
);

    // free running, first rising edge after half a period
    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2.0) clk = ~ clk;
    end

endmodule
